// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= glitch_monitor_tb
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG ?= Test completed successfully

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/glitch_pkg.sv ====
package glitch_pkg;

	// clock-cycle counts, saturating at all ones
	typedef logic [15:0] width_t;

	// rising edges seen in one session
	typedef logic [23:0] edge_cnt_t;

	// cycles from the first to the last rising edge
	typedef logic [31:0] span_t;

	// one kind of violation, saturating
	typedef logic [7:0] viol_cnt_t;

	// expected timing of the monitored signal
	localparam width_t PERIOD_CYC = 16'd8;
	localparam width_t HIGH_CYC = 16'd4;
	localparam width_t LOW_CYC = 16'd4;
	localparam width_t WIDTH_TOL = 16'd1;
	localparam width_t PERIOD_TOL = 16'd1;

	// slack on the whole span, not per period
	localparam span_t AVG_SLACK = 32'd2;
	localparam edge_cnt_t MIN_EDGES = 24'd16;

	typedef enum logic [1:0] {
		IDLE,
		RUNNING,
		REPORT
	} session_state_t;

	// only meaningful while strobe is set
	typedef struct packed {
		logic   strobe;
		logic   rise;
		logic   half_valid;
		width_t half_width;
		logic   period_valid;
		width_t period;
	} edge_meas_t;

	typedef struct packed {
		logic high_width;
		logic low_width;
		logic period;
	} viol_t;

	typedef struct packed {
		viol_cnt_t high;
		viol_cnt_t low;
		viol_cnt_t period;
	} viol_counts_t;

	typedef struct packed {
		logic         not_started;
		edge_cnt_t    edges;
		logic         too_few_edges;
		logic         avg_fail;
		viol_counts_t counts;
	} report_t;

endpackage

// ==== dv/glitch_monitor_tb.sv ====
`timescale 1ns/10ps

module glitch_monitor_tb;
	import glitch_pkg::*;

	localparam int CLK_NS = 10;
	// pattern cycles: clean 160, random at most 210, short 80, drift 180, restart 160
	localparam int PATTERN_CYC = 160 + 210 + 80 + 180 + 160;
	localparam int WATCHDOG_CYC = PATTERN_CYC + 200;

	logic    in;
	logic    rst;
	logic    sig;
	logic    start;
	logic    stop;
	logic    running;
	viol_t   viol;
	logic    report_valid;
	report_t report;

	// sig pattern as high and low half-cycle lengths, high first
	int      hi_len[$];
	int      lo_len[$];
	logic    quiet;

	// live viol pulses seen during the current session
	int      high_pulses;
	int      low_pulses;
	int      per_pulses;

	glitch_monitor i_glitch_monitor (
		.in           (in),
		.rst          (rst),
		.sig          (sig),
		.start        (start),
		.stop         (stop),
		.running      (running),
		.viol         (viol),
		.report_valid (report_valid),
		.report       (report)
	);

	initial begin
		in = 1'b0;
		forever #(CLK_NS / 2) in = ~in;
	end

	initial begin
		#(WATCHDOG_CYC * CLK_NS);
		fail_run("watchdog expired before all tests finished");
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_viol(input viol_t got, input viol_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error: viol = 0x%0h, expected 0x%0h", got, exp));
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_report(input report_t got, input report_t exp);
		check_field("report.not_started", 32'(got.not_started), 32'(exp.not_started));
		check_field("report.edges", 32'(got.edges), 32'(exp.edges));
		check_field("report.too_few_edges", 32'(got.too_few_edges), 32'(exp.too_few_edges));
		check_field("report.avg_fail", 32'(got.avg_fail), 32'(exp.avg_fail));
		check_field("report.counts.high", 32'(got.counts.high), 32'(exp.counts.high));
		check_field("report.counts.low", 32'(got.counts.low), 32'(exp.counts.low));
		check_field("report.counts.period", 32'(got.counts.period), 32'(exp.counts.period));
	endtask

	// tally of live pulses, none allowed while the clean run is playing
	always @(negedge in) begin
		if (quiet)
			check_viol(viol, '0);
		high_pulses += int'(viol.high_width);
		low_pulses += int'(viol.low_width);
		per_pulses += int'(viol.period);
	end

	function automatic bit in_range(input int v, input int nom, input int tol);
		return (v >= nom - tol) && (v <= nom + tol);
	endfunction

	// walks the pattern edge by edge
	task automatic compute_expected(output report_t exp);
		int n;
		int span;
		int exp_span;
		int high_v;
		int low_v;
		int per_v;
		n = hi_len.size();
		span = 0;
		high_v = 0;
		low_v = 0;
		per_v = 0;
		for (int i = 0; i < n; i++) begin
			// every fall follows a rise of the session
			if (!in_range(hi_len[i], int'(HIGH_CYC), int'(WIDTH_TOL)))
				high_v++;
			// the last low half-cycle never ends inside the session
			if (i < n - 1) begin
				span += hi_len[i] + lo_len[i];
				if (!in_range(lo_len[i], int'(LOW_CYC), int'(WIDTH_TOL)))
					low_v++;
			end
			if (i > 0) begin
				if (!in_range(hi_len[i-1] + lo_len[i-1], int'(PERIOD_CYC), int'(PERIOD_TOL)))
					per_v++;
				if (!in_range(lo_len[i-1] + hi_len[i], int'(PERIOD_CYC), int'(PERIOD_TOL)))
					per_v++;
			end
		end
		exp_span = (n - 1) * int'(PERIOD_CYC);
		exp = '0;
		exp.edges = edge_cnt_t'(n);
		exp.too_few_edges = n < int'(MIN_EDGES);
		exp.avg_fail = (n < 2) || (span < exp_span - int'(AVG_SLACK)) ||
			(span > exp_span + int'(AVG_SLACK));
		exp.counts.high = viol_cnt_t'(high_v);
		exp.counts.low = viol_cnt_t'(low_v);
		exp.counts.period = viol_cnt_t'(per_v);
	endtask

	task automatic load_clean(input int periods, input int high, input int low);
		hi_len.delete();
		lo_len.delete();
		repeat (periods) begin
			hi_len.push_back(high);
			lo_len.push_back(low);
		end
	endtask

	task automatic load_random();
		hi_len.delete();
		lo_len.delete();
		for (int i = 0; i < 20; i++) begin
			hi_len.push_back(3 + $urandom % 3);
			lo_len.push_back(3 + $urandom % 3);
			// 1-cycle high glitch splitting the low time
			if (i == 9) begin
				hi_len.push_back(1);
				lo_len.push_back(3);
			end
		end
	endtask

	// called on a falling edge, leaves sig low
	task automatic play_pattern();
		for (int i = 0; i < hi_len.size(); i++) begin
			sig = 1'b1;
			repeat (hi_len[i]) @(negedge in);
			sig = 1'b0;
			repeat (lo_len[i]) @(negedge in);
		end
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge in);
		start = 1'b0;
	endtask

	// report_valid is due on the third falling edge after stop goes high
	task automatic stop_and_collect(output report_t got);
		stop = 1'b1;
		@(negedge in);
		stop = 1'b0;
		if (report_valid)
			fail_run("report_valid arrived one cycle after stop, too early");
		@(negedge in);
		if (report_valid)
			fail_run("report_valid arrived at the first cycle after stop, too early");
		@(negedge in);
		if (!report_valid)
			fail_run("report_valid did not pulse 2 cycles after stop");
		got = report;
		@(negedge in);
		check_level("report_valid", report_valid, 1'b0);
	endtask

	task automatic run_session(input bit restart_mid);
		report_t exp;
		report_t got;
		compute_expected(exp);
		high_pulses = 0;
		low_pulses = 0;
		per_pulses = 0;
		pulse_start();
		repeat (6) @(negedge in);
		check_level("running", running, 1'b1);
		if (restart_mid) begin
			fork
				play_pattern();
				begin
					repeat (hi_len.size() * 4) @(negedge in);
					pulse_start();
				end
			join
		end else begin
			play_pattern();
		end
		repeat (6) @(negedge in);
		check_level("running", running, 1'b1);
		stop_and_collect(got);
		check_report(got, exp);
		check_field("viol.high_width pulses", 32'(high_pulses), 32'(exp.counts.high));
		check_field("viol.low_width pulses", 32'(low_pulses), 32'(exp.counts.low));
		check_field("viol.period pulses", 32'(per_pulses), 32'(exp.counts.period));
		check_level("running", running, 1'b0);
	endtask

	task automatic test_clean();
		load_clean(20, 4, 4);
		quiet = 1'b1;
		run_session(1'b0);
		quiet = 1'b0;
	endtask

	task automatic test_random_glitch();
		load_random();
		run_session(1'b0);
	endtask

	task automatic test_short_run();
		load_clean(10, 4, 4);
		run_session(1'b0);
	endtask

	// 9-cycle periods stay in tolerance but drift over the session
	task automatic test_drift();
		load_clean(20, 5, 4);
		run_session(1'b0);
	endtask

	task automatic test_stop_idle();
		report_t exp;
		report_t got;
		exp = '0;
		exp.not_started = 1'b1;
		stop_and_collect(got);
		check_report(got, exp);
		check_level("running", running, 1'b0);
	endtask

	task automatic test_restart_ignored();
		load_clean(20, 4, 4);
		run_session(1'b1);
	endtask

	initial begin
		void'($urandom(44));
		rst = 1'b1;
		sig = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		quiet = 1'b0;
		high_pulses = 0;
		low_pulses = 0;
		per_pulses = 0;
		repeat (16) @(negedge in);
		rst = 1'b0;
		@(negedge in);
		test_clean();
		test_random_glitch();
		test_short_run();
		test_drift();
		test_stop_idle();
		test_restart_ignored();
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== pulse_timer/pulse_timer.sv ====
`timescale 1ns/10ps

module pulse_timer (
	input  logic                   in,
	input  logic                   rst,
	input  logic                   sig,
	input  logic                   arm,
	input  logic                   running,
	output glitch_pkg::edge_meas_t meas
);
	import glitch_pkg::*;

	logic   sig_s1;
	logic   sig_s2;
	logic   sig_prev;
	logic   rise_q;
	logic   fall_q;
	logic   strobe;
	width_t cnt_edge;
	width_t cnt_rise;
	width_t cnt_fall;
	logic   seen_rise;
	logic   seen_fall;

	function automatic width_t sat_inc(input width_t v);
		sat_inc = (v == '1) ? v : v + width_t'(1);
	endfunction

	// two synchronizer stages, then the previous value for edge detect
	always_ff @(posedge in) begin
		if (rst) begin
			sig_s1 <= 1'b0;
			sig_s2 <= 1'b0;
			sig_prev <= 1'b0;
			rise_q <= 1'b0;
			fall_q <= 1'b0;
		end else begin
			sig_s1 <= sig;
			sig_s2 <= sig_s1;
			sig_prev <= sig_s2;
			rise_q <= sig_s2 & ~sig_prev;
			fall_q <= ~sig_s2 & sig_prev;
		end
	end

	// edges outside a session are dropped here
	assign strobe = (rise_q | fall_q) & running;

	// a counter restarted at 1 reads N on the strobe N cycles later
	always_ff @(posedge in) begin
		if (rst) begin
			cnt_edge <= '0;
			cnt_rise <= '0;
			cnt_fall <= '0;
			seen_rise <= 1'b0;
			seen_fall <= 1'b0;
		end else begin
			cnt_edge <= strobe ? width_t'(1) : sat_inc(cnt_edge);
			cnt_rise <= (strobe && rise_q) ? width_t'(1) : sat_inc(cnt_rise);
			cnt_fall <= (strobe && fall_q) ? width_t'(1) : sat_inc(cnt_fall);
			if (arm) begin
				seen_rise <= 1'b0;
				seen_fall <= 1'b0;
			end else if (strobe) begin
				if (rise_q)
					seen_rise <= 1'b1;
				else
					seen_fall <= 1'b1;
			end
		end
	end

	always_comb begin
		meas.strobe = strobe;
		meas.rise = rise_q;
		// the half-cycle that ends here began at an edge of the other kind
		meas.half_valid = strobe & (rise_q ? seen_fall : seen_rise);
		meas.half_width = cnt_edge;
		meas.period_valid = strobe & (rise_q ? seen_rise : seen_fall);
		meas.period = rise_q ? cnt_rise : cnt_fall;
	end

	a_meas_nonzero: assert property (@(posedge in) disable iff (rst)
		(meas.half_valid |-> meas.half_width != '0) and
		(meas.period_valid |-> meas.period != '0));

	a_no_strobe_idle: assert property (@(posedge in) disable iff (rst)
		!running |-> !meas.strobe);

endmodule

// ==== sources.f ====
common/glitch_pkg.sv
pulse_timer/pulse_timer.sv
src/width_checker.sv
src/session_ctrl.sv
src/glitch_monitor.sv
dv/glitch_monitor_tb.sv

// ==== src/glitch_monitor.sv ====
`timescale 1ns/10ps

module glitch_monitor (
	input  logic                in,
	input  logic                rst,
	input  logic                sig,
	input  logic                start,
	input  logic                stop,
	output logic                running,
	output glitch_pkg::viol_t   viol,
	output logic                report_valid,
	output glitch_pkg::report_t report
);
	import glitch_pkg::*;

	edge_meas_t   meas;
	viol_counts_t counts;
	logic         arm;

	pulse_timer i_pulse_timer (
		.in      (in),
		.rst     (rst),
		.sig     (sig),
		.arm     (arm),
		.running (running),
		.meas    (meas)
	);

	width_checker i_width_checker (
		.in      (in),
		.rst     (rst),
		.meas    (meas),
		.arm     (arm),
		.running (running),
		.viol    (viol),
		.counts  (counts)
	);

	// owns the session and assembles the report
	session_ctrl i_session_ctrl (
		.in           (in),
		.rst          (rst),
		.start        (start),
		.stop         (stop),
		.meas         (meas),
		.counts       (counts),
		.arm          (arm),
		.running      (running),
		.report_valid (report_valid),
		.report       (report)
	);

endmodule

// ==== src/session_ctrl.sv ====
`timescale 1ns/10ps

module session_ctrl (
	input  logic                     in,
	input  logic                     rst,
	input  logic                     start,
	input  logic                     stop,
	input  glitch_pkg::edge_meas_t   meas,
	input  glitch_pkg::viol_counts_t counts,
	output logic                     arm,
	output logic                     running,
	output logic                     report_valid,
	output glitch_pkg::report_t      report
);
	import glitch_pkg::*;

	session_state_t state;
	logic           start_q;
	logic           start_qq;
	logic           stop_q;
	logic           stop_qq;
	logic           start_rise;
	logic           stop_rise;
	logic           stop_idle;
	logic           rise_strobe;
	edge_cnt_t      edges;
	span_t          cyc;
	span_t          span;
	span_t          exp_span;
	report_t        report_next;

	assign start_rise = start_q & ~start_qq;
	assign stop_rise = stop_q & ~stop_qq;
	assign arm = (state == IDLE) & start_rise;
	assign running = (state == RUNNING);
	assign rise_strobe = meas.strobe & meas.rise & running;

	always_ff @(posedge in) begin
		if (rst) begin
			state <= IDLE;
			start_q <= 1'b0;
			start_qq <= 1'b0;
			stop_q <= 1'b0;
			stop_qq <= 1'b0;
			stop_idle <= 1'b0;
			report_valid <= 1'b0;
		end else begin
			start_q <= start;
			start_qq <= start_q;
			stop_q <= stop;
			stop_qq <= stop_q;
			report_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (start_rise) begin
						state <= RUNNING;
						stop_idle <= 1'b0;
					end else if (stop_rise) begin
						state <= REPORT;
						stop_idle <= 1'b1;
					end
				end
				RUNNING: begin
					if (stop_rise)
						state <= REPORT;
				end
				// one extra cycle for the last viol pulse to reach counts
				REPORT: begin
					report_valid <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// cyc reads k on a rising strobe k cycles after the first one
	always_ff @(posedge in) begin
		if (rst || arm) begin
			edges <= '0;
			cyc <= '0;
			span <= '0;
		end else begin
			if (running && edges != '0)
				cyc <= cyc + span_t'(1);
			if (rise_strobe) begin
				if (edges != '1)
					edges <= edges + edge_cnt_t'(1);
				if (edges == '0)
					cyc <= span_t'(1);
				else
					span <= cyc;
			end
		end
	end

	// wraps for edges of 0, which the edge-count test covers
	assign exp_span = (span_t'(edges) - span_t'(1)) * span_t'(PERIOD_CYC);

	always_comb begin
		report_next = '0;
		report_next.not_started = stop_idle;
		if (!stop_idle) begin
			report_next.edges = edges;
			report_next.too_few_edges = edges < MIN_EDGES;
			report_next.avg_fail = (edges < edge_cnt_t'(2)) ||
				(span < exp_span - AVG_SLACK) || (span > exp_span + AVG_SLACK);
			report_next.counts = counts;
		end
	end

	always_ff @(posedge in) begin
		if (state == REPORT)
			report <= report_next;
	end

	a_report_pulse: assert property (@(posedge in) disable iff (rst)
		report_valid |=> !report_valid);

	a_arm_idle: assert property (@(posedge in) disable iff (rst)
		arm |-> (state == IDLE) ##1 running);

endmodule

// ==== src/width_checker.sv ====
`timescale 1ns/10ps

module width_checker (
	input  logic                     in,
	input  logic                     rst,
	input  glitch_pkg::edge_meas_t   meas,
	input  logic                     arm,
	input  logic                     running,
	output glitch_pkg::viol_t        viol,
	output glitch_pkg::viol_counts_t counts
);
	import glitch_pkg::*;

	logic  check;
	viol_t viol_next;

	// a saturated count stands for an unknown, too long width
	function automatic logic out_of_bounds(
		input width_t v,
		input width_t nom,
		input width_t tol
	);
		out_of_bounds = (v == '1) || (v < nom - tol) || (v > nom + tol);
	endfunction

	function automatic viol_cnt_t sat_add(input viol_cnt_t c, input logic hit);
		sat_add = (hit && c != '1) ? c + viol_cnt_t'(1) : c;
	endfunction

	assign check = meas.strobe & running;

	// a falling strobe closes a high half-cycle, a rising one a low half-cycle
	always_comb begin
		viol_next.high_width = check & meas.half_valid & ~meas.rise &
			out_of_bounds(meas.half_width, HIGH_CYC, WIDTH_TOL);
		viol_next.low_width = check & meas.half_valid & meas.rise &
			out_of_bounds(meas.half_width, LOW_CYC, WIDTH_TOL);
		viol_next.period = check & meas.period_valid &
			out_of_bounds(meas.period, PERIOD_CYC, PERIOD_TOL);
	end

	always_ff @(posedge in) begin
		if (rst) begin
			viol <= '0;
			counts <= '0;
		end else begin
			viol <= viol_next;
			if (arm) begin
				counts <= '0;
			end else begin
				counts.high <= sat_add(counts.high, viol_next.high_width);
				counts.low <= sat_add(counts.low, viol_next.low_width);
				counts.period <= sat_add(counts.period, viol_next.period);
			end
		end
	end

	// every pulse traces back to a strobe one cycle earlier
	a_viol_after_strobe: assert property (@(posedge in) disable iff (rst)
		!meas.strobe |=> viol == '0);

endmodule
